// File: sim.f
+incdir+.
realign_cfg_pkg.sv
rvc_pkg.sv
fetch_if.sv
fetch_stage.sv
realign_core.sv
slot_out_stage.sv
instr_realign_top.sv
tb_instr_realign.sv

// File: run_sim.sh
#!/bin/sh
# builds the realigner testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir

verilator --binary --timing --top-module tb_instr_realign \
    -f sim.f --Mdir "$MDIR" -o tb_instr_realign
if [ $? -ne 0 ]; then
    echo "build with Verilator failed"
    exit 1
fi

"./$MDIR/tb_instr_realign" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: tb_realign_model.svh
/*
 * reference model of the realign rules and the flush, plus random stimulus helpers
 */
`ifndef TB_REALIGN_MODEL_SVH
`define TB_REALIGN_MODEL_SVH

// outputs expected from one driven cycle, due two edges after it is driven
typedef struct packed {
    logic [1:0]      valid;
    logic [31:0]     instr0;
    logic [31:0]     instr1;
    logic [VLEN-1:0] addr0;
    logic [VLEN-1:0] addr1;
    logic            unaligned;
} expect_t;

expect_t         expect_q[$];
// set while the first parcel of a 32-bit instruction waits for its second
logic            m_hold;
logic [15:0]     m_buf_half;
logic [VLEN-1:0] m_buf_addr;

// a parcel is compressed unless both low opcode bits are set
function automatic logic half_is_compressed(input logic [15:0] half);
    return (half[1:0] != 2'b11);
endfunction

function automatic logic [31:0] zero_extend(input logic [15:0] half);
    return {16'h0000, half};
endfunction

// --------------------
// realign rules
// --------------------
task automatic model_fetch(
    input  logic            valid,
    input  logic [VLEN-1:0] addr,
    input  logic [31:0]     data,
    input  logic            kill,
    output expect_t         e
);
    logic [15:0]     lo;
    logic [15:0]     hi;
    logic [VLEN-1:0] hi_addr;
    logic            take_upper;

    lo         = data[15:0];
    hi         = data[31:16];
    // word address plus two bytes
    hi_addr    = (addr & ~VLEN'(3)) + VLEN'(2);
    take_upper = 1'b0;
    e          = '0;

    if (kill) begin
        // a flush drops this fetch and restarts from the aligned state
        m_hold = 1'b0;
    end else if (valid) begin
        if (addr[1]) begin
            // branch target on the upper halfword, any buffered parcel is stale
            if (half_is_compressed(lo)) begin
                e.valid[0] = 1'b1;
                e.instr0   = zero_extend(lo);
                e.addr0    = addr;
                m_hold     = 1'b0;
            end else begin
                m_buf_half = lo;
                m_buf_addr = addr;
                m_hold     = 1'b1;
            end
        end else if (m_hold) begin
            // lower parcel is the second half of the buffered instruction
            e.valid[0] = 1'b1;
            e.instr0   = {lo, m_buf_half};
            e.addr0    = m_buf_addr;
            take_upper = 1'b1;
        end else if (half_is_compressed(lo)) begin
            e.valid[0] = 1'b1;
            e.instr0   = zero_extend(lo);
            e.addr0    = addr;
            take_upper = 1'b1;
        end else begin
            e.valid[0] = 1'b1;
            e.instr0   = data;
            e.addr0    = addr;
        end

        if (take_upper) begin
            if (half_is_compressed(hi)) begin
                e.valid[1] = 1'b1;
                e.instr1   = zero_extend(hi);
                e.addr1    = hi_addr;
                m_hold     = 1'b0;
            end else begin
                m_buf_half = hi;
                m_buf_addr = hi_addr;
                m_hold     = 1'b1;
            end
        end
    end
    // the status output shows the state after this fetch
    e.unaligned = m_hold;
endtask

// --------------------
// stimulus helpers
// --------------------
// random parcel whose two low bits select the requested length
function automatic logic [15:0] random_half(input logic compressed);
    logic [15:0] half;
    half = 16'($urandom);
    if (compressed) begin
        half[1:0] = 2'($urandom_range(2, 0));
    end else begin
        half[1:0] = 2'b11;
    end
    return half;
endfunction

// each parcel is compressed or full-length with equal odds
function automatic logic [31:0] random_word();
    logic [31:0] word;
    word = {random_half(1'($urandom)), random_half(1'($urandom))};
    return word;
endfunction

// jump target somewhere in the address space, always on an upper halfword
function automatic logic [VLEN-1:0] random_upper_addr();
    logic [63:0] raw;
    raw = {$urandom, $urandom};
    return {raw[VLEN-1:2], 2'b10};
endfunction

`endif

// File: tb_instr_realign.sv
/*
 * testbench for the instruction realigner, directed cases and a random run
 */
`timescale 1ns/1ps
`default_nettype none

module tb_instr_realign;
    import realign_cfg_pkg::*;

    localparam int unsigned VLEN            = 39;
    localparam int unsigned RESET_CYCLES    = 16;
    localparam int unsigned DIRECTED_CYCLES = 40;
    localparam int unsigned RANDOM_CYCLES   = 400;
    // every planned cycle plus a margin of 100
    localparam int unsigned WATCHDOG_CYCLES =
        RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 100;

    // known encodings for the directed cases
    localparam logic [15:0] C_LI   = 16'h4501;
    localparam logic [15:0] C_ADDI = 16'h0485;
    localparam logic [31:0] ADD    = 32'h00a50533;

    logic                                 clk;
    logic                                 reset;
    logic                                 flush;
    logic                                 fetch_valid;
    logic [VLEN-1:0]                      fetch_addr;
    fetch_word_t                          fetch_data;
    slot_valid_t                          out_valid;
    instr_t [INSTR_PER_FETCH-1:0]         out_instr;
    logic [INSTR_PER_FETCH-1:0][VLEN-1:0] out_addr;
    logic                                 out_unaligned;

    `include "tb_realign_model.svh"

    instr_realign_top #(.VLEN(VLEN)) u_instr_realign_top (
        .clk_i               (clk),
        .reset_i             (reset),
        .flush_i             (flush),
        .valid_i             (fetch_valid),
        .address_i           (fetch_addr),
        .data_i              (fetch_data),
        .valid_o             (out_valid),
        .instr_o             (out_instr),
        .addr_o              (out_addr),
        .serving_unaligned_o (out_unaligned)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs();
        expect_t e;
        e = expect_q.pop_front();
        check_value("valid_o", 64'(out_valid), 64'(e.valid));
        check_value("serving_unaligned_o", 64'(out_unaligned), 64'(e.unaligned));
        // data and address only mean something where the slot is valid
        if (e.valid[0]) begin
            check_value("instr_o[0]", 64'(out_instr[0]), 64'(e.instr0));
            check_value("addr_o[0]", 64'(out_addr[0]), 64'(e.addr0));
        end
        if (e.valid[1]) begin
            check_value("instr_o[1]", 64'(out_instr[1]), 64'(e.instr1));
            check_value("addr_o[1]", 64'(out_addr[1]), 64'(e.addr1));
        end
    endtask

    // --------------------
    // one clock cycle
    // --------------------
    // outputs are compared just after the edge, then the next fetch is driven
    task automatic run_cycle(input logic v, input logic [VLEN-1:0] a,
                             input fetch_word_t d, input logic f);
        expect_t e;
        @(posedge clk);
        #1;
        compare_outputs();
        fetch_valid = v;
        fetch_addr  = a;
        fetch_data  = d;
        flush       = f;
        model_fetch(v, a, d, f, e);
        // the flush also kills the fetch one cycle ahead in the pipeline
        if (f) begin
            expect_q[expect_q.size()-1] = '0;
        end
        expect_q.push_back(e);
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) run_cycle(1'b0, '0, '0, 1'b0);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the simulation hung", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin : test_sequence
        logic            v;
        logic            f;
        logic [VLEN-1:0] rand_addr;

        void'($urandom(18761));
        reset       = 1'b1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        fetch_data  = '0;
        m_hold      = 1'b0;
        m_buf_half  = '0;
        m_buf_addr  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("valid_o", 64'(out_valid), 64'd0);
        check_value("serving_unaligned_o", 64'(out_unaligned), 64'd0);
        // the two cycles already in the pipeline were idle under reset
        expect_q.push_back('0);
        expect_q.push_back('0);
        idle_cycles(4);

        // --------------------
        // sequential words
        // --------------------
        run_cycle(1'b1, VLEN'(32'h1000), {C_ADDI, C_LI}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h1004), ADD, 1'b0);
        // upper parcel starts a 32-bit instruction that spills into 0x100c
        run_cycle(1'b1, VLEN'(32'h1008), {16'h0513, C_LI}, 1'b0);
        idle_cycles(1);
        run_cycle(1'b1, VLEN'(32'h100c), {16'h4505, 16'h0010}, 1'b0);
        idle_cycles(2);

        // --------------------
        // upper-half starts
        // --------------------
        run_cycle(1'b1, VLEN'(32'h2002), {16'hffff, C_LI}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h2006), {16'hffff, 16'h0593}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h2008), {C_LI, 16'h00b5}, 1'b0);
        // branch targets that land while a parcel is buffered
        run_cycle(1'b1, VLEN'(32'h3000), {16'h0613, C_LI}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h3102), {16'hffff, C_ADDI}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h3200), {16'h0613, C_LI}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h3306), {16'hffff, 16'h0693}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h3308), {C_ADDI, 16'h0000}, 1'b0);
        idle_cycles(2);

        // --------------------
        // flush
        // --------------------
        // the second word leaves its upper parcel buffered when the flush hits
        run_cycle(1'b1, VLEN'(32'h4000), {16'h0713, C_LI}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h4004), {16'h0793, C_ADDI}, 1'b0);
        run_cycle(1'b1, VLEN'(32'h4008), ADD, 1'b1);
        run_cycle(1'b1, VLEN'(32'h5000), ADD, 1'b0);
        idle_cycles(3);

        // --------------------
        // random run
        // --------------------
        rand_addr = VLEN'(32'h0001_0000);
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            v = ($urandom_range(3, 0) != 0);
            f = ($urandom_range(24, 0) == 0);
            if (v && $urandom_range(11, 0) == 0) begin
                rand_addr = random_upper_addr();
            end
            run_cycle(v, rand_addr, random_word(), f);
            // the next fetch continues at the following word
            if (v) begin
                rand_addr = {rand_addr[VLEN-1:2], 2'b00} + VLEN'(4);
            end
        end
        idle_cycles(3);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: instr_realign_top.sv
/*
 * instruction realigner top, input register, realign core and output register
 */
`timescale 1ns/1ps
`default_nettype none

module instr_realign_top #(
    parameter int unsigned VLEN = 39
) (
    input  logic                                                  clk_i,
    input  logic                                                  reset_i,
    input  logic                                                  flush_i,
    input  logic                                                  valid_i,
    input  logic [VLEN-1:0]                                       address_i,
    input  realign_cfg_pkg::fetch_word_t                          data_i,
    output realign_cfg_pkg::slot_valid_t                          valid_o,
    output realign_cfg_pkg::instr_t [realign_cfg_pkg::INSTR_PER_FETCH-1:0] instr_o,
    output logic [realign_cfg_pkg::INSTR_PER_FETCH-1:0][VLEN-1:0] addr_o,
    output logic                                                  serving_unaligned_o
);

    // slots from the core into the output register
    realign_cfg_pkg::slot_valid_t                          slot_valid;
    realign_cfg_pkg::instr_t [realign_cfg_pkg::INSTR_PER_FETCH-1:0] slot_instr;
    logic [realign_cfg_pkg::INSTR_PER_FETCH-1:0][VLEN-1:0] slot_addr;

    // registered fetch with its predecoded parcels
    fetch_if #(.VLEN(VLEN)) u_fetch_if ();

    fetch_stage #(.VLEN(VLEN)) u_fetch_stage (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .flush_i   (flush_i),
        .valid_i   (valid_i),
        .address_i (address_i),
        .data_i    (data_i),
        .fetch_o   (u_fetch_if.source)
    );

    // the core state updates on the same edge the output register loads,
    // so the unaligned status lines up with the registered slots
    realign_core #(.VLEN(VLEN)) u_realign_core (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .flush_i             (flush_i),
        .fetch_i             (u_fetch_if.sink),
        .slot_valid_o        (slot_valid),
        .slot_instr_o        (slot_instr),
        .slot_addr_o         (slot_addr),
        .serving_unaligned_o (serving_unaligned_o)
    );

    slot_out_stage #(.VLEN(VLEN)) u_slot_out_stage (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .slot_valid_i (slot_valid),
        .slot_instr_i (slot_instr),
        .slot_addr_i  (slot_addr),
        .valid_o      (valid_o),
        .instr_o      (instr_o),
        .addr_o       (addr_o)
    );

endmodule

`default_nettype wire

// File: slot_out_stage.sv
/*
 * output register for the two instruction slots
 */
`timescale 1ns/1ps
`default_nettype none

module slot_out_stage #(
    parameter int unsigned VLEN = 39
) (
    input  logic                                                  clk_i,
    input  logic                                                  reset_i,
    input  logic                                                  flush_i,
    input  realign_cfg_pkg::slot_valid_t                          slot_valid_i,
    input  realign_cfg_pkg::instr_t [realign_cfg_pkg::INSTR_PER_FETCH-1:0] slot_instr_i,
    input  logic [realign_cfg_pkg::INSTR_PER_FETCH-1:0][VLEN-1:0] slot_addr_i,
    output realign_cfg_pkg::slot_valid_t                          valid_o,
    output realign_cfg_pkg::instr_t [realign_cfg_pkg::INSTR_PER_FETCH-1:0] instr_o,
    output logic [realign_cfg_pkg::INSTR_PER_FETCH-1:0][VLEN-1:0] addr_o
);

    // --------------------
    // valid bits
    // --------------------
    // a flush kills the slots of the fetch the core is presenting right now,
    // so nothing older than the flush reaches the decoder
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            valid_o <= '0;
        end else begin
            valid_o <= slot_valid_i;
        end
    end

    // --------------------
    // slot payload
    // --------------------
    // instruction and address follow the core every cycle and are only
    // meaningful where the matching valid bit is set
    always_ff @(posedge clk_i) begin
        instr_o <= slot_instr_i;
        addr_o  <= slot_addr_i;
    end

endmodule

`default_nettype wire

// File: realign_core.sv
/*
 * half-instruction buffer and slot formation for 32-bit fetch words
 * turns one predecoded fetch into up to two instructions with addresses
 */
`timescale 1ns/1ps
`default_nettype none

module realign_core #(
    parameter int unsigned VLEN = 39
) (
    input  logic                                                  clk_i,
    input  logic                                                  reset_i,
    input  logic                                                  flush_i,
    fetch_if.sink                                                 fetch_i,
    output realign_cfg_pkg::slot_valid_t                          slot_valid_o,
    output realign_cfg_pkg::instr_t [realign_cfg_pkg::INSTR_PER_FETCH-1:0] slot_instr_o,
    output logic [realign_cfg_pkg::INSTR_PER_FETCH-1:0][VLEN-1:0] slot_addr_o,
    output logic                                                  serving_unaligned_o
);
    import realign_cfg_pkg::*;
    import rvc_pkg::*;

    half_t           lower_half;
    half_t           upper_half;
    logic [VLEN-1:0] upper_addr;

    realign_state_e  state_q;
    realign_state_e  state_d;
    half_t           buf_half_q;
    half_t           buf_half_d;
    logic [VLEN-1:0] buf_addr_q;
    logic [VLEN-1:0] buf_addr_d;
    logic            buf_load;
    // the upper parcel still has to be looked at after slot 0 is formed
    logic            use_upper;

    assign lower_half = fetch_i.data[HALF_WIDTH-1:0];
    assign upper_half = fetch_i.data[FETCH_WIDTH-1:HALF_WIDTH];
    // address of the upper parcel, taken from the word address
    assign upper_addr = {fetch_i.address[VLEN-1:2], UPPER_HALF_OFFSET};

    // --------------------
    // slot formation
    // --------------------
    always_comb begin
        // slot 1 only ever carries the upper parcel, so its data is fixed
        slot_valid_o    = '0;
        slot_instr_o[0] = fetch_i.data;
        slot_addr_o[0]  = fetch_i.address;
        slot_instr_o[1] = {{HALF_WIDTH{1'b0}}, upper_half};
        slot_addr_o[1]  = upper_addr;

        state_d    = state_q;
        buf_load   = 1'b0;
        buf_half_d = upper_half;
        buf_addr_d = upper_addr;
        use_upper  = 1'b0;

        if (fetch_i.valid) begin
            if (fetch_i.address[1]) begin
                // branch into the upper halfword, the cache hands it over in the
                // lower half and any buffered parcel is stale
                if (fetch_i.compressed[0]) begin
                    slot_valid_o[0] = 1'b1;
                    slot_instr_o[0] = {{HALF_WIDTH{1'b0}}, lower_half};
                    state_d         = ALIGNED;
                end else begin
                    // only the first parcel of a 32-bit instruction is here
                    buf_load   = 1'b1;
                    buf_half_d = lower_half;
                    buf_addr_d = fetch_i.address;
                    state_d    = HOLD_UPPER;
                end
            end else if (state_q == HOLD_UPPER) begin
                // the lower parcel completes the buffered instruction
                slot_valid_o[0] = 1'b1;
                slot_instr_o[0] = {lower_half, buf_half_q};
                slot_addr_o[0]  = buf_addr_q;
                use_upper       = 1'b1;
            end else if (fetch_i.compressed[0]) begin
                slot_valid_o[0] = 1'b1;
                slot_instr_o[0] = {{HALF_WIDTH{1'b0}}, lower_half};
                use_upper       = 1'b1;
            end else begin
                // plain aligned 32-bit instruction, the whole word is slot 0
                slot_valid_o[0] = 1'b1;
                state_d         = ALIGNED;
            end

            // upper parcel is either a compressed instruction of its own or
            // the start of the next 32-bit one
            if (use_upper) begin
                if (fetch_i.compressed[1]) begin
                    slot_valid_o[1] = 1'b1;
                    state_d         = ALIGNED;
                end else begin
                    buf_load = 1'b1;
                    state_d  = HOLD_UPPER;
                end
            end
        end
    end

    // --------------------
    // state and buffer
    // --------------------
    // state follows the fetch valid through state_d, which keeps state_q
    // when nothing arrives
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            state_q <= ALIGNED;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (buf_load) begin
            buf_half_q <= buf_half_d;
            buf_addr_q <= buf_addr_d;
        end
    end

    // high while slot 0 of the next fetch will be a joined instruction
    assign serving_unaligned_o = (state_q == HOLD_UPPER);

endmodule

`default_nettype wire

// File: fetch_stage.sv
/*
 * input register for one fetch word plus predecode of its two halfwords
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter int unsigned VLEN = 39
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        flush_i,
    input  logic                        valid_i,
    input  logic [VLEN-1:0]             address_i,
    input  realign_cfg_pkg::fetch_word_t data_i,
    fetch_if.source                     fetch_o
);
    import realign_cfg_pkg::*;
    import rvc_pkg::*;

    logic [INSTR_PER_FETCH-1:0] compressed_d;
    logic [INSTR_PER_FETCH-1:0] compressed_q;
    logic                       valid_q;
    logic [VLEN-1:0]            address_q;
    fetch_word_t                data_q;

    // --------------------
    // predecode
    // --------------------
    // each parcel is checked on its own, the realigner decides later which
    // parcels actually start an instruction
    always_comb begin
        for (int i = 0; i < INSTR_PER_FETCH; i++) begin
            compressed_d[i] = (data_i[i*HALF_WIDTH +: 2] != OPCODE_FULL);
        end
    end

    // --------------------
    // fetch register
    // --------------------
    // a flush drops whatever is being captured on this edge
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // payload only moves with a valid fetch, the valid bit qualifies it
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            address_q    <= address_i;
            data_q       <= data_i;
            compressed_q <= compressed_d;
        end
    end

    assign fetch_o.valid      = valid_q;
    assign fetch_o.address    = address_q;
    assign fetch_o.data       = data_q;
    assign fetch_o.compressed = compressed_q;

endmodule

`default_nettype wire

// File: fetch_if.sv
/*
 * registered and predecoded fetch, from the input stage to the realigner
 */
`timescale 1ns/1ps
`default_nettype none

interface fetch_if #(
    parameter int unsigned VLEN = 39
) ();
    import realign_cfg_pkg::*;

    // the fetch held in the input register is valid this cycle
    logic                       valid;
    // virtual address of the fetch, bit 1 set for an upper-half start
    logic [VLEN-1:0]            address;
    fetch_word_t                data;
    // one bit per halfword, set when that parcel is compressed
    logic [INSTR_PER_FETCH-1:0] compressed;

    modport source (output valid, output address, output data, output compressed);
    modport sink   (input valid, input address, input data, input compressed);

endinterface

`default_nettype wire

// File: rvc_pkg.sv
/*
 * compressed-encoding constants and halfword offsets of the instruction set
 */
`default_nettype none

package rvc_pkg;

    // --------------------
    // opcode length
    // --------------------
    // a parcel whose two low bits are 11 starts a 32-bit instruction
    // any other value in these bits marks a 16-bit compressed instruction
    parameter logic [1:0] OPCODE_FULL = 2'b11;

    // --------------------
    // parcel placement
    // --------------------
    // byte offset of the upper halfword inside a 32-bit fetch word
    // appended to the word address to form the address of slot 1
    parameter logic [1:0] UPPER_HALF_OFFSET = 2'b10;

endpackage

`default_nettype wire

// File: realign_cfg_pkg.sv
/*
 * fetch geometry, vector typedefs and realigner state encoding
 */
`default_nettype none

package realign_cfg_pkg;

    // one fetch word carries two halfwords
    parameter int unsigned FETCH_WIDTH     = 32;
    parameter int unsigned HALF_WIDTH      = 16;
    parameter int unsigned INSTR_PER_FETCH = 2;

    // raw fetch data as it comes from the instruction cache
    typedef logic [FETCH_WIDTH-1:0]     fetch_word_t;
    // a single 16-bit parcel of the fetch word
    typedef logic [HALF_WIDTH-1:0]      half_t;
    // an instruction slot, compressed parcels are zero-extended into it
    typedef logic [31:0]                instr_t;
    // one valid bit per instruction slot
    typedef logic [INSTR_PER_FETCH-1:0] slot_valid_t;

    // ALIGNED means the next fetch starts a fresh instruction
    // HOLD_UPPER means the lower half of a 32-bit instruction waits in the buffer
    typedef enum logic {
        ALIGNED    = 1'b0,
        HOLD_UPPER = 1'b1
    } realign_state_e;

endpackage

`default_nettype wire
